// File: project.f
fetchPkg.sv
frontendPkg.sv
preDecode.sv
returnStack.sv
bimodalTable.sv
branchPredict.sv
pcGenerate.sv
fetchUnit.sv
frontendTop.sv
frontendAsserts.sv
frontendTb.sv

// File: Makefile
# Verilator build and run of the frontend testbench.
VERILATOR ?= verilator
TOP       ?= frontendTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIMARGS   ?= +verilator+error+limit+100
PASSMSG   ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: frontendTb.sv
// frontend testbench, plays instruction memory from a table of fetches and checks the pc stream.
module frontendTb;
	timeunit 1ns;
	timeprecision 1ps;

	import fetchPkg::*;
	import frontendPkg::*;

	// what the execute side does once a row's word has been fetched.
	typedef enum logic [2:0] {actNone, actTaken, actNotTaken, actJalr, actExcept} actionE;

	localparam int numRows = 25;
	localparam int cycleLimit = 40 * numRows;
	localparam logic [instWidth-1:0] nop = 32'h0000_0013; // addi x0, x0, 0.

	logic CLK = 1'b0;
	logic arstN;
	logic imemReq;
	logic [addrWidth-1:0] imemAddr;
	logic imemAck;
	logic [instWidth-1:0] imemData;
	logic jalrValid;
	logic [addrWidth-1:0] jalrPc;
	logic bruResValid;
	logic bruTakenBranch;
	logic privilegedValid;
	logic [addrWidth-1:0] privilegedPc;
	logic isMisPredict;

	// program table, one row per fetch seen on the bus.
	logic [addrWidth-1:0] rowAddr [numRows];
	logic [instWidth-1:0] rowInst [numRows];
	actionE rowAct [numRows];
	logic [addrWidth-1:0] rowActPc [numRows];
	logic rowMis [numRows];
	int rowCount = 0;

	integer seed;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	always #50 CLK = ~CLK; // 100 ns period.

	frontendTop dut (
		.CLK             (CLK),
		.arstN           (arstN),
		.imemReq         (imemReq),
		.imemAddr        (imemAddr),
		.imemAck         (imemAck),
		.imemData        (imemData),
		.jalrValid       (jalrValid),
		.jalrPc          (jalrPc),
		.bruResValid     (bruResValid),
		.bruTakenBranch  (bruTakenBranch),
		.privilegedValid (privilegedValid),
		.privilegedPc    (privilegedPc),
		.isMisPredict    (isMisPredict)
	);

	// instruction encoders, straight from the isa field layout.
	function automatic logic [instWidth-1:0] encJal(input logic [4:0] rd, input logic [20:0] off);
		encJal = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	function automatic logic [instWidth-1:0] encBeq(input logic [12:0] off);
		encBeq = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], opBranch}; // x0 == x0.
	endfunction

	function automatic logic [instWidth-1:0] encJalr(input logic [4:0] rd, input logic [4:0] rs1);
		encJalr = {12'd0, rs1, 3'b000, rd, opJalr};
	endfunction

	task automatic addRow(input logic [addrWidth-1:0] addr, input logic [instWidth-1:0] inst,
			input actionE act, input logic [addrWidth-1:0] actPc, input logic mis);
		rowAddr[rowCount] = addr;
		rowInst[rowCount] = inst;
		rowAct[rowCount] = act;
		rowActPc[rowCount] = actPc;
		rowMis[rowCount] = mis;
		rowCount++;
	endtask

	task automatic loadProgram();
		addRow(64'h8000_0000, nop, actNone, '0, 1'b0); // reset vector.
		addRow(64'h8000_0004, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0008, encJal(5'd0, 21'h18), actNone, '0, 1'b0); // plain jump.
		addRow(64'h8000_0020, encJal(5'd1, 21'h40), actNone, '0, 1'b0); // call, links 0x24.
		addRow(64'h8000_0060, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0064, encJalr(5'd0, 5'd1), actNone, '0, 1'b0); // return.
		addRow(64'h8000_0024, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0028, nop, actNone, '0, 1'b0);
		addRow(64'h8000_002C, encBeq(-13'sd8), actTaken, '0, 1'b1); // weak not-taken, wrong.
		addRow(64'h8000_0030, encJalr(5'd0, 5'd6), actNone, '0, 1'b0); // squashed.
		addRow(64'h8000_0024, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0028, nop, actNone, '0, 1'b0);
		addRow(64'h8000_002C, encBeq(-13'sd8), actTaken, '0, 1'b0); // now predicted taken.
		addRow(64'h8000_0024, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0028, nop, actNone, '0, 1'b0);
		addRow(64'h8000_002C, encBeq(-13'sd8), actNotTaken, '0, 1'b1); // loop exit.
		addRow(64'h8000_0024, nop, actNone, '0, 1'b0); // squashed.
		addRow(64'h8000_0030, encJalr(5'd0, 5'd6), actJalr, 64'h8000_0100, 1'b0);
		addRow(64'h8000_0100, nop, actNone, '0, 1'b0);
		addRow(64'h8000_0104, encBeq(13'sd32), actNotTaken, '0, 1'b0);
		addRow(64'h8000_0108, nop, actNone, '0, 1'b0);
		addRow(64'h8000_010C, encBeq(13'sd64), actExcept, 64'h8000_0200, 1'b0);
		addRow(64'h8000_0110, encJal(5'd0, 21'h100), actNone, '0, 1'b0); // must not run.
		addRow(64'h8000_0200, nop, actNone, '0, 1'b0); // trap handler.
		addRow(64'h8000_0204, nop, actNone, '0, 1'b0);
	endtask

	task automatic checkAddr(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp,
			input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic waitReq();
		while (imemReq !== 1'b1) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// memory side, random ack delay then the four-phase tail.
	task automatic serveFetch(input logic [instWidth-1:0] word);
		int delay;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) begin
			@(posedge CLK);
			#1;
		end
		imemData = word;
		imemAck = 1'b1;
		do begin
			@(posedge CLK);
			#1;
		end while (imemReq);
		imemAck = 1'b0; // req is down.
	endtask

	// one-cycle execute pulse, a cycle after the word reached the predictor.
	task automatic applyAction(input actionE act, input logic [addrWidth-1:0] pc);
		@(posedge CLK);
		#1;
		case (act)
			actTaken, actNotTaken: begin
				bruResValid = 1'b1;
				bruTakenBranch = (act == actTaken);
			end
			actJalr: begin
				repeat (4) begin
					@(posedge CLK);
					#1;
				end
				checkFlag(imemReq, 1'b0, "imemReq while waiting for jalr"); // stalled.
				jalrValid = 1'b1;
				jalrPc = pc;
			end
			actExcept: begin
				privilegedValid = 1'b1;
				privilegedPc = pc;
			end
			default: ;
		endcase
		@(posedge CLK);
		#1;
		bruResValid = 1'b0;
		jalrValid = 1'b0;
		privilegedValid = 1'b0;
	endtask

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: fetch stalled");
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		int rowErrors;
		int totalErrors;
		seed = 89009;
		arstN = 1'b0;
		imemAck = 1'b0;
		imemData = '0;
		jalrValid = 1'b0;
		jalrPc = '0;
		bruResValid = 1'b0;
		bruTakenBranch = 1'b0;
		privilegedValid = 1'b0;
		privilegedPc = '0;
		loadProgram();
		repeat (16) @(posedge CLK);
		#1;
		arstN = 1'b1;
		checkFlag(imemReq, 1'b0, "imemReq after reset");
		checkFlag(isMisPredict, 1'b0, "isMisPredict after reset");
		for (int i = 0; i < numRows; i++) begin
			rowErrors = errorCount;
			waitReq();
			checkAddr(imemAddr, rowAddr[i], "fetch address");
			serveFetch(rowInst[i]);
			applyAction(rowAct[i], rowActPc[i]);
			checkFlag(isMisPredict, rowMis[i], "isMisPredict");
			$display("row %0d fetch %h action %s %s", i, rowAddr[i], rowAct[i].name(),
				(errorCount == rowErrors) ? "ok" : "wrong");
		end
		totalErrors = errorCount + dut.protocolCheck.assertFails;
		$display("%0d rows, %0d checks, %0d errors, %0d assertion failures", numRows,
			checkCount, errorCount, dut.protocolCheck.assertFails);
		if (totalErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: frontendAsserts.sv
// checker for the imem handshake and the mispredict pulse that the bind below attaches to the top.
module frontendAsserts (
	input logic                           CLK,
	input logic                           arstN,
	input logic                           imemReq,
	input logic [fetchPkg::addrWidth-1:0] imemAddr,
	input logic                           imemAck,
	input logic                           isMisPredict
);
	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0; // failed assertion count.

	// req only rises once ack has fallen.
	reqRiseAckLow: assert property (@(posedge CLK) disable iff (!arstN)
		$rose(imemReq) |-> !$past(imemAck))
	else begin
		$error("imemReq rose while imemAck was still high");
		assertFails++;
	end

	// address held for the whole req phase.
	addrStable: assert property (@(posedge CLK) disable iff (!arstN)
		(imemReq && $past(imemReq)) |-> (imemAddr == $past(imemAddr)))
	else begin
		$error("imemAddr changed while imemReq was high");
		assertFails++;
	end

	// one mispredict pulse per resolution.
	misPulse: assert property (@(posedge CLK) disable iff (!arstN)
		isMisPredict |=> !isMisPredict)
	else begin
		$error("isMisPredict high in two consecutive cycles");
		assertFails++;
	end

endmodule

bind frontendTop frontendAsserts protocolCheck (
	.CLK          (CLK),
	.arstN        (arstN),
	.imemReq      (imemReq),
	.imemAddr     (imemAddr),
	.imemAck      (imemAck),
	.isMisPredict (isMisPredict)
);

// File: frontendTop.sv
// frontend top, fetch unit plus pre-decode plus pc generation, memory and execute ports outside.
module frontendTop (
	input  logic                           CLK,
	input  logic                           arstN,
	output logic                           imemReq,
	output logic [fetchPkg::addrWidth-1:0] imemAddr,
	input  logic                           imemAck,
	input  logic [fetchPkg::instWidth-1:0] imemData,
	input  logic                           jalrValid,
	input  logic [fetchPkg::addrWidth-1:0] jalrPc,
	input  logic                           bruResValid,
	input  logic                           bruTakenBranch,
	input  logic                           privilegedValid,
	input  logic [fetchPkg::addrWidth-1:0] privilegedPc,
	output logic                           isMisPredict
);
	import fetchPkg::*;

	logic [addrWidth-1:0] fetchAddr;
	logic fetchAddrValid;
	logic flush;
	logic fetchBusy;
	logic fetchPcValid;
	logic [addrWidth-1:0] fetchPc;
	logic [instWidth-1:0] fetchInst;
	logic isJal;
	logic isJalr;
	logic isBranch;
	logic isCall;
	logic isReturn;
	logic [addrWidth-1:0] imm;

	fetchUnit iFetchUnit (
		.CLK            (CLK),
		.arstN          (arstN),
		.fetchAddr      (fetchAddr),
		.fetchAddrValid (fetchAddrValid),
		.flush          (flush),
		.fetchBusy      (fetchBusy),
		.imemReq        (imemReq),
		.imemAddr       (imemAddr),
		.imemAck        (imemAck),
		.imemData       (imemData),
		.fetchPcValid   (fetchPcValid),
		.fetchPc        (fetchPc),
		.fetchInst      (fetchInst)
	);

	preDecode iPreDecode (
		.inst     (fetchInst),
		.isJal    (isJal),
		.isJalr   (isJalr),
		.isBranch (isBranch),
		.isCall   (isCall),
		.isReturn (isReturn),
		.imm      (imm)
	);

	pcGenerate iPcGenerate (
		.CLK             (CLK),
		.arstN           (arstN),
		.privilegedValid (privilegedValid),
		.privilegedPc    (privilegedPc),
		.jalrValid       (jalrValid),
		.jalrPc          (jalrPc),
		.bruResValid     (bruResValid),
		.bruTakenBranch  (bruTakenBranch),
		.fetchPcValid    (fetchPcValid),
		.fetchPcQueue    (fetchPc),
		.isJal           (isJal),
		.isJalr          (isJalr),
		.isBranch        (isBranch),
		.isCall          (isCall),
		.isReturn        (isReturn),
		.imm             (imm),
		.fetchBusy       (fetchBusy),
		.isMisPredict    (isMisPredict),
		.flush           (flush),
		.fetchAddrQout   (fetchAddr),
		.fetchAddrValid  (fetchAddrValid)
	);

endmodule

// File: fetchUnit.sv
// four-phase req/ack master to instruction memory, one fetch in flight, drops flushed responses.
module fetchUnit (
	input  logic                           CLK,
	input  logic                           arstN,
	input  logic [fetchPkg::addrWidth-1:0] fetchAddr,
	input  logic                           fetchAddrValid,
	input  logic                           flush,
	output logic                           fetchBusy,
	output logic                           imemReq,
	output logic [fetchPkg::addrWidth-1:0] imemAddr,
	input  logic                           imemAck,
	input  logic [fetchPkg::instWidth-1:0] imemData,
	output logic                           fetchPcValid,
	output logic [fetchPkg::addrWidth-1:0] fetchPc,
	output logic [fetchPkg::instWidth-1:0] fetchInst
);
	import fetchPkg::*;

	fetchStateE state;
	logic stale; // response of the running handshake is junk.
	logic queued; // next address taken while ack still high.

	assign imemReq = (state == reqHigh);
	assign fetchBusy = (state != idle);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			stale <= 1'b0;
			queued <= 1'b0;
			fetchPcValid <= 1'b0;
		end else begin
			fetchPcValid <= 1'b0;
			case (state)
				idle: begin
					if (fetchAddrValid) begin
						state <= reqHigh; // ack is already low here.
					end
				end
				reqHigh: begin
					if (flush) begin
						stale <= 1'b1;
					end
					if (imemAck) begin
						fetchPcValid <= !stale && !flush; // squashed, no pulse.
						stale <= 1'b0;
						state <= waitAckLow;
					end
				end
				default: begin
					// req may rise again only once ack is low.
					if (!imemAck) begin
						state <= (fetchAddrValid || (queued && !flush)) ? reqHigh : idle;
						queued <= 1'b0;
					end else begin
						queued <= fetchAddrValid || (queued && !flush);
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (fetchAddrValid && (state != reqHigh)) begin
			imemAddr <= fetchAddr; // held through the whole req phase.
		end
		if ((state == reqHigh) && imemAck) begin
			fetchPc <= imemAddr;
			fetchInst <= imemData;
		end
	end

endmodule

// File: pcGenerate.sv
// frontend control wrapper, maps exception ports onto the predictor and guards its training.
module pcGenerate (
	input  logic                           CLK,
	input  logic                           arstN,
	input  logic                           privilegedValid,
	input  logic [fetchPkg::addrWidth-1:0] privilegedPc,
	input  logic                           jalrValid,
	input  logic [fetchPkg::addrWidth-1:0] jalrPc,
	input  logic                           bruResValid,
	input  logic                           bruTakenBranch,
	input  logic                           fetchPcValid,
	input  logic [fetchPkg::addrWidth-1:0] fetchPcQueue,
	input  logic                           isJal,
	input  logic                           isJalr,
	input  logic                           isBranch,
	input  logic                           isCall,
	input  logic                           isReturn,
	input  logic [fetchPkg::addrWidth-1:0] imm,
	input  logic                           fetchBusy,
	output logic                           isMisPredict,
	output logic                           flush,
	output logic [fetchPkg::addrWidth-1:0] fetchAddrQout,
	output logic                           fetchAddrValid
);

	logic bruResKeep;

	// exception kills the branch in the same cycle, so no training either.
	assign bruResKeep = bruResValid && !privilegedValid;

	branchPredict iBranchPredict (
		.CLK            (CLK),
		.arstN          (arstN),
		.isJal          (isJal),
		.isJalr         (isJalr),
		.isBranch       (isBranch),
		.isCall         (isCall),
		.isReturn       (isReturn),
		.imm            (imm),
		.isExpection    (privilegedValid),
		.expectionPc    (privilegedPc),
		.jalrValid      (jalrValid),
		.jalrPc         (jalrPc),
		.bruResValid    (bruResKeep),
		.bruTakenBranch (bruTakenBranch),
		.fetchPcValid   (fetchPcValid),
		.fetchPc        (fetchPcQueue),
		.fetchBusy      (fetchBusy),
		.fetchAddr      (fetchAddrQout),
		.fetchAddrValid (fetchAddrValid),
		.isMisPredict   (isMisPredict),
		.flush          (flush)
	);

endmodule

// File: branchPredict.sv
// next fetch address selection with bimodal and return-stack prediction and redirect on resolve.
module branchPredict (
	input  logic                           CLK,
	input  logic                           arstN,
	input  logic                           isJal,
	input  logic                           isJalr,
	input  logic                           isBranch,
	input  logic                           isCall,
	input  logic                           isReturn,
	input  logic [fetchPkg::addrWidth-1:0] imm,
	input  logic                           isExpection,
	input  logic [fetchPkg::addrWidth-1:0] expectionPc,
	input  logic                           jalrValid,
	input  logic [fetchPkg::addrWidth-1:0] jalrPc,
	input  logic                           bruResValid,
	input  logic                           bruTakenBranch,
	input  logic                           fetchPcValid,
	input  logic [fetchPkg::addrWidth-1:0] fetchPc,
	input  logic                           fetchBusy,
	output logic [fetchPkg::addrWidth-1:0] fetchAddr,
	output logic                           fetchAddrValid,
	output logic                           isMisPredict,
	output logic                           flush
);
	import fetchPkg::*;

	predStateE state;
	logic pendValid; // one unresolved branch at most.
	logic pendTaken;
	logic [addrWidth-1:0] pendPc;
	logic [addrWidth-1:0] pendAlt; // path not predicted.
	logic redirPend; // redirect waiting for the fetch unit.
	logic [addrWidth-1:0] redirAddr;
	logic predTaken;
	logic rasEmpty;
	logic [addrWidth-1:0] rasTop;
	logic [addrWidth-1:0] seqPc;
	logic [addrWidth-1:0] jumpPc;
	logic [addrWidth-1:0] redirTarget;
	logic [addrWidth-1:0] nextPc;
	logic [addrWidth-1:0] issueAddr;
	logic mispredict;
	logic redirect;
	logic issueBusy;
	logic accept;
	logic goWait;
	logic issue;

	assign seqPc = fetchPc + addrWidth'(4);
	assign jumpPc = fetchPc + imm;
	assign mispredict = bruResValid && pendValid && (bruTakenBranch != pendTaken);
	assign redirect = isExpection || mispredict; // exception wins.
	assign redirTarget = isExpection ? expectionPc : pendAlt;
	assign issueBusy = fetchBusy || fetchAddrValid; // a fetch is in flight or just issued.
	// decoded word only counts when nothing overrides it this cycle.
	assign accept = fetchPcValid && !redirect && !redirPend && (state == run);

	// predicted target for the word just fetched.
	always_comb begin
		nextPc = seqPc;
		goWait = 1'b0;
		if (isJal) begin
			nextPc = jumpPc;
		end else if (isJalr) begin
			if (isReturn && !rasEmpty) begin
				nextPc = rasTop;
			end else begin
				goWait = 1'b1; // target only known at execute.
			end
		end else if (isBranch && predTaken) begin
			nextPc = jumpPc;
		end
	end

	// what goes to the fetch unit next edge, redirects first.
	always_comb begin
		issue = 1'b0;
		issueAddr = nextPc;
		if (redirect) begin
			issue = !issueBusy;
			issueAddr = redirTarget;
		end else if (redirPend) begin
			issue = !issueBusy;
			issueAddr = redirAddr;
		end else if (state == waitJalr) begin
			issue = jalrValid;
			issueAddr = jalrPc;
		end else begin
			issue = accept && !goWait;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= run;
			pendValid <= 1'b0;
			redirPend <= 1'b1; // first fetch goes out as a redirect.
			redirAddr <= resetVector;
			fetchAddrValid <= 1'b0;
			isMisPredict <= 1'b0;
			flush <= 1'b0;
		end else begin
			fetchAddrValid <= issue;
			isMisPredict <= mispredict && !isExpection;
			flush <= redirect;
			redirPend <= (redirect || redirPend) && issueBusy;
			if (redirect) begin
				redirAddr <= redirTarget;
			end
			if (redirect) begin
				state <= run;
			end else if (!redirPend && (state == waitJalr) && jalrValid) begin
				state <= run;
			end else if (accept && goWait) begin
				state <= waitJalr;
			end
			if (redirect) begin
				pendValid <= 1'b0;
			end else if (accept && isBranch) begin
				pendValid <= 1'b1;
			end else if (bruResValid) begin
				pendValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			fetchAddr <= issueAddr;
		end
		if (accept && isBranch) begin
			pendPc <= fetchPc;
			pendTaken <= predTaken;
			pendAlt <= predTaken ? seqPc : jumpPc;
		end
	end

	bimodalTable iBimodalTable (
		.CLK       (CLK),
		.arstN     (arstN),
		.predPc    (fetchPc),
		.predTaken (predTaken),
		.updValid  (bruResValid && pendValid),
		.updPc     (pendPc),
		.updTaken  (bruTakenBranch)
	);

	returnStack iReturnStack (
		.CLK      (CLK),
		.arstN    (arstN),
		.push     (accept && isCall), // link is pc plus 4.
		.pushAddr (seqPc),
		.pop      (accept && isReturn && !rasEmpty),
		.top      (rasTop),
		.empty    (rasEmpty)
	);

endmodule

// File: bimodalTable.sv
// two-bit saturating counter table, read by fetch pc and trained by resolved branches.
module bimodalTable (
	input  logic                           CLK,
	input  logic                           arstN,
	input  logic [fetchPkg::addrWidth-1:0] predPc,
	output logic                           predTaken,
	input  logic                           updValid,
	input  logic [fetchPkg::addrWidth-1:0] updPc,
	input  logic                           updTaken
);
	import frontendPkg::*;

	logic [1:0] ctr [bhtEntries];
	logic [$clog2(bhtEntries)-1:0] predIdx;
	logic [$clog2(bhtEntries)-1:0] updIdx;
	logic [1:0] updCtr;

	// drop the word offset, pc[7:2].
	assign predIdx = predPc[2 +: $clog2(bhtEntries)];
	assign updIdx = updPc[2 +: $clog2(bhtEntries)];

	assign predTaken = ctr[predIdx][1]; // 2 or 3 means taken.
	assign updCtr = ctr[updIdx];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < bhtEntries; i++) begin
				ctr[i] <= ctrInit;
			end
		end else if (updValid) begin
			// saturate at both ends.
			if (updTaken && (updCtr != 2'b11)) begin
				ctr[updIdx] <= updCtr + 2'b01;
			end else if (!updTaken && (updCtr != 2'b00)) begin
				ctr[updIdx] <= updCtr - 2'b01;
			end
		end
	end

endmodule

// File: returnStack.sv
// circular return address stack, call pushes the link address and return pops it.
module returnStack (
	input  logic                           CLK,
	input  logic                           arstN,
	input  logic                           push,
	input  logic [fetchPkg::addrWidth-1:0] pushAddr,
	input  logic                           pop,
	output logic [fetchPkg::addrWidth-1:0] top,
	output logic                           empty
);
	import fetchPkg::*;
	import frontendPkg::*;

	typedef logic [$clog2(rasDepth+1)-1:0] cntT;

	logic [addrWidth-1:0] stack [rasDepth];
	logic [$clog2(rasDepth)-1:0] ptr; // next free slot.
	logic [$clog2(rasDepth)-1:0] topIdx;
	cntT cnt; // valid entries, saturates at depth.
	logic doPop;

	assign empty = (cnt == '0);
	assign topIdx = ptr - 1'b1; // wraps, depth is a power of two.
	assign top = stack[topIdx];
	assign doPop = pop && !empty; // pop on empty is ignored.

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ptr <= '0;
			cnt <= '0;
		end else if (push && !doPop) begin
			ptr <= ptr + 1'b1; // when full this lands on the oldest entry.
			if (cnt != cntT'(rasDepth)) begin
				cnt <= cnt + 1'b1;
			end
		end else if (doPop && !push) begin
			ptr <= topIdx;
			cnt <= cnt - 1'b1;
		end
	end

	// push with pop replaces the top in place.
	always_ff @(posedge CLK) begin
		if (push) begin
			stack[doPop ? topIdx : ptr] <= pushAddr;
		end
	end

endmodule

// File: preDecode.sv
// combinational pre-decoder, flags control-flow instructions and builds their immediate.
module preDecode (
	input  logic [fetchPkg::instWidth-1:0] inst,
	output logic                           isJal,
	output logic                           isJalr,
	output logic                           isBranch,
	output logic                           isCall,
	output logic                           isReturn,
	output logic [fetchPkg::addrWidth-1:0] imm
);
	import fetchPkg::*;
	import frontendPkg::*;

	opcodeE opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic rdLink;
	logic rs1Link;

	// map the raw opcode field onto the classes we care about.
	always_comb begin
		case (inst[6:0])
			opJal:    opcode = opJal;
			opJalr:   opcode = opJalr;
			opBranch: opcode = opBranch;
			default:  opcode = opOther;
		endcase
	end

	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rdLink = (rd == linkRa) || (rd == linkT0); // writes a link reg.
	assign rs1Link = (rs1 == linkRa) || (rs1 == linkT0);

	assign isJal = (opcode == opJal);
	assign isJalr = (opcode == opJalr);
	assign isBranch = (opcode == opBranch);
	assign isCall = (isJal || isJalr) && rdLink; // link write means call.
	assign isReturn = isJalr && rs1Link && !rdLink; // jump through link, no relink.

	// sign-extended j and b immediates, bit 0 always zero.
	always_comb begin
		case (opcode)
			opJal:    imm = {{(addrWidth-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			opBranch: imm = {{(addrWidth-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			default:  imm = '0; // jalr target comes from ras or execute.
		endcase
	end

endmodule

// File: frontendPkg.sv
// instruction classes, link registers and predictor sizing, imported by decode and predictor.
package frontendPkg;

	// major opcodes the pre-decoder tells apart.
	typedef enum logic [6:0] {
		opJal    = 7'b1101111, // unconditional pc-relative jump.
		opJalr   = 7'b1100111, // register-indirect jump.
		opBranch = 7'b1100011, // conditional branch, b-type.
		opOther  = 7'b0000000  // anything else falls through.
	} opcodeE;

	// link registers per the calling convention.
	// rd or rs1 equal to one of these marks a call or return.
	localparam logic [4:0] linkRa = 5'd1; // x1, ra.
	localparam logic [4:0] linkT0 = 5'd5; // x5, alternate link.

	// bimodal table size.
	// index comes from pc bits above the word offset.
	localparam int bhtEntries = 64;

	// return stack depth, power of two so the pointer wraps for free.
	localparam int rasDepth = 4;

	// counter start value.
	// weakly not-taken, one taken result flips it.
	localparam logic [1:0] ctrInit = 2'b01;

	// counter encoding, for reference.
	//   00 strongly not-taken
	//   01 weakly not-taken
	//   10 weakly taken
	//   11 strongly taken
	// msb is the prediction.

endpackage

// File: fetchPkg.sv
// address and instruction widths plus fetch and predictor state encodings for the frontend.
package fetchPkg;

	localparam int addrWidth = 64; // virtual pc width.
	localparam int instWidth = 32; // no rvc, always full words.

	// first fetch address after reset.
	localparam logic [addrWidth-1:0] resetVector = 64'h8000_0000;

	// four-phase master states.
	typedef enum logic [1:0] {
		idle,      // no handshake running.
		reqHigh,   // req up, waiting for ack.
		waitAckLow // req dropped, waiting for ack to fall.
	} fetchStateE;

	// predictor issue states.
	typedef enum logic {run, waitJalr} predStateE;

endpackage
